// File: hw/la_isa_pkg.sv
`default_nettype none

package la_isa_pkg;

    // 2RI16 major opcodes, inst[31:26]
    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;
    localparam logic [5:0] OP_BLT  = 6'h18;
    localparam logic [5:0] OP_BGE  = 6'h19;
    localparam logic [5:0] OP_BLTU = 6'h1a;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0] OP_SLTI  = 10'h008;
    localparam logic [9:0] OP_SLTUI = 10'h009;
    localparam logic [9:0] OP_ADDI  = 10'h00a;
    localparam logic [9:0] OP_ANDI  = 10'h00d;
    localparam logic [9:0] OP_ORI   = 10'h00e;
    localparam logic [9:0] OP_XORI  = 10'h00f;

    // 3R opcodes, inst[31:15]
    localparam logic [16:0] OP_ADD  = 17'h00020;
    localparam logic [16:0] OP_SUB  = 17'h00022;
    localparam logic [16:0] OP_SLT  = 17'h00024;
    localparam logic [16:0] OP_SLTU = 17'h00025;
    localparam logic [16:0] OP_NOR  = 17'h00028;
    localparam logic [16:0] OP_AND  = 17'h00029;
    localparam logic [16:0] OP_OR   = 17'h0002a;
    localparam logic [16:0] OP_XOR  = 17'h0002b;

    typedef struct packed {
        logic [5:0]  op6;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri16_t;

    typedef struct packed {
        logic [9:0]  op10;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [16:0] op17;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    // one fetched word seen through each format
    typedef union packed {
        fmt_2ri16_t fmt_2ri16;
        fmt_2ri12_t fmt_2ri12;
        fmt_3r_t    fmt_3r;
    } inst_word_u;

endpackage

`default_nettype wire

// File: hw/la_ctrl_pkg.sv
`default_nettype none

package la_ctrl_pkg;

    // alu operations
    localparam logic [7:0] ALU_NOP  = 8'h00;
    localparam logic [7:0] ALU_ADD  = 8'h01;
    localparam logic [7:0] ALU_SUB  = 8'h02;
    localparam logic [7:0] ALU_SLT  = 8'h03;
    localparam logic [7:0] ALU_SLTU = 8'h04;
    localparam logic [7:0] ALU_AND  = 8'h05;
    localparam logic [7:0] ALU_OR   = 8'h06;
    localparam logic [7:0] ALU_XOR  = 8'h07;
    localparam logic [7:0] ALU_NOR  = 8'h08;
    localparam logic [7:0] ALU_BEQ  = 8'h10;
    localparam logic [7:0] ALU_BNE  = 8'h11;
    localparam logic [7:0] ALU_BLT  = 8'h12;
    localparam logic [7:0] ALU_BGE  = 8'h13;
    localparam logic [7:0] ALU_BLTU = 8'h14;
    localparam logic [7:0] ALU_BGEU = 8'h15;
    localparam logic [7:0] ALU_B    = 8'h16;
    localparam logic [7:0] ALU_BL   = 8'h17;
    localparam logic [7:0] ALU_JIRL = 8'h18;

    // result class for the execute mux
    localparam logic [2:0] SEL_NOP         = 3'd0;
    localparam logic [2:0] SEL_LOGIC       = 3'd1;
    localparam logic [2:0] SEL_ARITH       = 3'd2;
    localparam logic [2:0] SEL_JUMP_BRANCH = 3'd3;

    // ecode for instruction not exist
    localparam logic [6:0] EXC_INE = 7'h0d;

endpackage

`default_nettype wire

// File: hw/id_2ri16.sv
`timescale 1ns/1ps
`default_nettype none

module id_2ri16 (
    input  la_isa_pkg::inst_word_u inst,
    output logic                   hit,
    output logic [7:0]             aluop,
    output logic [2:0]             alusel,
    output logic [31:0]            imm,
    output logic                   reg1_read_en,
    output logic                   reg2_read_en,
    output logic [4:0]             reg1_read_addr,
    output logic [4:0]             reg2_read_addr,
    output logic                   reg_write_en,
    output logic [4:0]             reg_write_addr
);

    logic [25:0] offs26;
    logic [31:0] br_imm;
    logic [31:0] jmp_imm;

    // B/BL offset spills into the register fields
    assign offs26  = {inst.fmt_2ri16.rj, inst.fmt_2ri16.rd, inst.fmt_2ri16.offs16};
    assign br_imm  = {{14{inst.fmt_2ri16.offs16[15]}}, inst.fmt_2ri16.offs16, 2'b00};
    assign jmp_imm = {{4{offs26[25]}}, offs26, 2'b00};

    always_comb begin
        hit            = 1'b1;
        aluop          = la_ctrl_pkg::ALU_NOP;
        alusel         = la_ctrl_pkg::SEL_JUMP_BRANCH;
        imm            = br_imm;
        reg1_read_en   = 1'b1;
        reg2_read_en   = 1'b1;
        reg1_read_addr = inst.fmt_2ri16.rj;
        reg2_read_addr = inst.fmt_2ri16.rd; // branches compare rj with rd
        reg_write_en   = 1'b0;
        reg_write_addr = 5'd0;
        case (inst.fmt_2ri16.op6)
            la_isa_pkg::OP_BEQ:  aluop = la_ctrl_pkg::ALU_BEQ;
            la_isa_pkg::OP_BNE:  aluop = la_ctrl_pkg::ALU_BNE;
            la_isa_pkg::OP_BLT:  aluop = la_ctrl_pkg::ALU_BLT;
            la_isa_pkg::OP_BGE:  aluop = la_ctrl_pkg::ALU_BGE;
            la_isa_pkg::OP_BLTU: aluop = la_ctrl_pkg::ALU_BLTU;
            la_isa_pkg::OP_BGEU: aluop = la_ctrl_pkg::ALU_BGEU;
            la_isa_pkg::OP_B: begin
                aluop          = la_ctrl_pkg::ALU_B;
                imm            = jmp_imm;
                reg1_read_en   = 1'b0;
                reg2_read_en   = 1'b0;
                reg1_read_addr = 5'd0;
                reg2_read_addr = 5'd0;
            end
            la_isa_pkg::OP_BL: begin
                aluop          = la_ctrl_pkg::ALU_BL;
                imm            = jmp_imm;
                reg1_read_en   = 1'b0;
                reg2_read_en   = 1'b0;
                reg1_read_addr = 5'd0;
                reg2_read_addr = 5'd0;
                reg_write_en   = 1'b1;
                reg_write_addr = 5'd1; // link register
            end
            la_isa_pkg::OP_JIRL: begin
                aluop          = la_ctrl_pkg::ALU_JIRL;
                reg2_read_en   = 1'b0;
                reg2_read_addr = 5'd0;
                reg_write_en   = 1'b1;
                reg_write_addr = inst.fmt_2ri16.rd;
            end
            default: begin
                hit            = 1'b0;
                alusel         = la_ctrl_pkg::SEL_NOP;
                imm            = 32'd0;
                reg1_read_en   = 1'b0;
                reg2_read_en   = 1'b0;
                reg1_read_addr = 5'd0;
                reg2_read_addr = 5'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/id_2ri12.sv
`timescale 1ns/1ps
`default_nettype none

module id_2ri12 (
    input  la_isa_pkg::inst_word_u inst,
    output logic                   hit,
    output logic [7:0]             aluop,
    output logic [2:0]             alusel,
    output logic [31:0]            imm,
    output logic                   reg1_read_en,
    output logic                   reg2_read_en,
    output logic [4:0]             reg1_read_addr,
    output logic [4:0]             reg2_read_addr,
    output logic                   reg_write_en,
    output logic [4:0]             reg_write_addr
);

    logic [31:0] simm;
    logic [31:0] uimm;

    assign simm = {{20{inst.fmt_2ri12.si12[11]}}, inst.fmt_2ri12.si12};
    assign uimm = {20'd0, inst.fmt_2ri12.si12}; // logic ops zero-extend

    always_comb begin
        hit            = 1'b1;
        aluop          = la_ctrl_pkg::ALU_NOP;
        alusel         = la_ctrl_pkg::SEL_ARITH;
        imm            = simm;
        reg1_read_en   = 1'b1;
        reg2_read_en   = 1'b0;
        reg1_read_addr = inst.fmt_2ri12.rj;
        reg2_read_addr = 5'd0;
        reg_write_en   = 1'b1;
        reg_write_addr = inst.fmt_2ri12.rd;
        case (inst.fmt_2ri12.op10)
            la_isa_pkg::OP_ADDI:  aluop = la_ctrl_pkg::ALU_ADD;
            la_isa_pkg::OP_SLTI:  aluop = la_ctrl_pkg::ALU_SLT;
            la_isa_pkg::OP_SLTUI: aluop = la_ctrl_pkg::ALU_SLTU;
            la_isa_pkg::OP_ANDI: begin
                aluop  = la_ctrl_pkg::ALU_AND;
                alusel = la_ctrl_pkg::SEL_LOGIC;
                imm    = uimm;
            end
            la_isa_pkg::OP_ORI: begin
                aluop  = la_ctrl_pkg::ALU_OR;
                alusel = la_ctrl_pkg::SEL_LOGIC;
                imm    = uimm;
            end
            la_isa_pkg::OP_XORI: begin
                aluop  = la_ctrl_pkg::ALU_XOR;
                alusel = la_ctrl_pkg::SEL_LOGIC;
                imm    = uimm;
            end
            default: begin
                hit            = 1'b0;
                alusel         = la_ctrl_pkg::SEL_NOP;
                imm            = 32'd0;
                reg1_read_en   = 1'b0;
                reg1_read_addr = 5'd0;
                reg_write_en   = 1'b0;
                reg_write_addr = 5'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/id_3r.sv
`timescale 1ns/1ps
`default_nettype none

module id_3r (
    input  la_isa_pkg::inst_word_u inst,
    output logic                   hit,
    output logic [7:0]             aluop,
    output logic [2:0]             alusel,
    output logic [31:0]            imm,
    output logic                   reg1_read_en,
    output logic                   reg2_read_en,
    output logic [4:0]             reg1_read_addr,
    output logic [4:0]             reg2_read_addr,
    output logic                   reg_write_en,
    output logic [4:0]             reg_write_addr
);

    assign imm = 32'd0; // no immediate in 3R

    always_comb begin
        hit            = 1'b1;
        aluop          = la_ctrl_pkg::ALU_NOP;
        alusel         = la_ctrl_pkg::SEL_ARITH;
        reg1_read_en   = 1'b1;
        reg2_read_en   = 1'b1;
        reg1_read_addr = inst.fmt_3r.rj;
        reg2_read_addr = inst.fmt_3r.rk;
        reg_write_en   = 1'b1;
        reg_write_addr = inst.fmt_3r.rd;
        case (inst.fmt_3r.op17)
            la_isa_pkg::OP_ADD:  aluop = la_ctrl_pkg::ALU_ADD;
            la_isa_pkg::OP_SUB:  aluop = la_ctrl_pkg::ALU_SUB;
            la_isa_pkg::OP_SLT:  aluop = la_ctrl_pkg::ALU_SLT;
            la_isa_pkg::OP_SLTU: aluop = la_ctrl_pkg::ALU_SLTU;
            la_isa_pkg::OP_AND: begin
                aluop  = la_ctrl_pkg::ALU_AND;
                alusel = la_ctrl_pkg::SEL_LOGIC;
            end
            la_isa_pkg::OP_OR: begin
                aluop  = la_ctrl_pkg::ALU_OR;
                alusel = la_ctrl_pkg::SEL_LOGIC;
            end
            la_isa_pkg::OP_XOR: begin
                aluop  = la_ctrl_pkg::ALU_XOR;
                alusel = la_ctrl_pkg::SEL_LOGIC;
            end
            la_isa_pkg::OP_NOR: begin
                aluop  = la_ctrl_pkg::ALU_NOR;
                alusel = la_ctrl_pkg::SEL_LOGIC;
            end
            default: begin
                hit            = 1'b0;
                alusel         = la_ctrl_pkg::SEL_NOP;
                reg1_read_en   = 1'b0;
                reg2_read_en   = 1'b0;
                reg1_read_addr = 5'd0;
                reg2_read_addr = 5'd0;
                reg_write_en   = 1'b0;
                reg_write_addr = 5'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire        clk,
    input  wire        rst,
    input  wire        we,
    input  wire  [4:0] waddr,
    input  wire [31:0] wdata,
    input  wire        re1,
    input  wire  [4:0] raddr1,
    input  wire        re2,
    input  wire  [4:0] raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        if (!re1 || raddr1 == 5'd0) begin
            rdata1 = 32'd0;
        end else if (we && waddr == raddr1) begin
            rdata1 = wdata; // bypass same-cycle writeback
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (!re2 || raddr2 == 5'd0) begin
            rdata2 = 32'd0;
        end else if (we && waddr == raddr2) begin
            rdata2 = wdata;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire         clk,
    input  wire         rst,
    input  wire         if_valid,
    input  wire  [31:0] pc,
    input  wire  [31:0] inst,
    input  wire         stall,
    input  wire         flush,
    input  wire         wb_en,
    input  wire   [4:0] wb_addr,
    input  wire  [31:0] wb_data,
    output logic        ex_valid,
    output logic [31:0] ex_pc,
    output logic [31:0] ex_inst,
    output logic  [7:0] ex_aluop,
    output logic  [2:0] ex_alusel,
    output logic [31:0] ex_imm,
    output logic [31:0] ex_reg1_data,
    output logic [31:0] ex_reg2_data,
    output logic        ex_reg_write_en,
    output logic  [4:0] ex_reg_write_addr,
    output logic        ex_exception,
    output logic  [6:0] ex_exception_cause
);

    // decoder bundles, index 0: 2RI16, 1: 2RI12, 2: 3R
    logic  [2:0] dec_hit;
    logic  [7:0] dec_aluop [3];
    logic  [2:0] dec_alusel [3];
    logic [31:0] dec_imm [3];
    logic  [2:0] dec_re1;
    logic  [2:0] dec_re2;
    logic  [4:0] dec_raddr1 [3];
    logic  [4:0] dec_raddr2 [3];
    logic  [2:0] dec_we;
    logic  [4:0] dec_waddr [3];

    logic  [7:0] sel_aluop;
    logic  [2:0] sel_alusel;
    logic [31:0] sel_imm;
    logic        sel_re1;
    logic        sel_re2;
    logic  [4:0] sel_raddr1;
    logic  [4:0] sel_raddr2;
    logic        sel_we;
    logic  [4:0] sel_waddr;
    logic        no_hit;
    logic [31:0] rdata1;
    logic [31:0] rdata2;

    id_2ri16 u_id_2ri16 (
        .inst(inst), .hit(dec_hit[0]), .aluop(dec_aluop[0]), .alusel(dec_alusel[0]),
        .imm(dec_imm[0]), .reg1_read_en(dec_re1[0]), .reg2_read_en(dec_re2[0]),
        .reg1_read_addr(dec_raddr1[0]), .reg2_read_addr(dec_raddr2[0]),
        .reg_write_en(dec_we[0]), .reg_write_addr(dec_waddr[0])
    );

    id_2ri12 u_id_2ri12 (
        .inst(inst), .hit(dec_hit[1]), .aluop(dec_aluop[1]), .alusel(dec_alusel[1]),
        .imm(dec_imm[1]), .reg1_read_en(dec_re1[1]), .reg2_read_en(dec_re2[1]),
        .reg1_read_addr(dec_raddr1[1]), .reg2_read_addr(dec_raddr2[1]),
        .reg_write_en(dec_we[1]), .reg_write_addr(dec_waddr[1])
    );

    id_3r u_id_3r (
        .inst(inst), .hit(dec_hit[2]), .aluop(dec_aluop[2]), .alusel(dec_alusel[2]),
        .imm(dec_imm[2]), .reg1_read_en(dec_re1[2]), .reg2_read_en(dec_re2[2]),
        .reg1_read_addr(dec_raddr1[2]), .reg2_read_addr(dec_raddr2[2]),
        .reg_write_en(dec_we[2]), .reg_write_addr(dec_waddr[2])
    );

    assign no_hit = ~|dec_hit; // nobody claims the word

    // opcode spaces are disjoint so at most one hit
    always_comb begin
        sel_aluop  = la_ctrl_pkg::ALU_NOP;
        sel_alusel = la_ctrl_pkg::SEL_NOP;
        sel_imm    = 32'd0;
        sel_re1    = 1'b0;
        sel_re2    = 1'b0;
        sel_raddr1 = 5'd0;
        sel_raddr2 = 5'd0;
        sel_we     = 1'b0;
        sel_waddr  = 5'd0;
        for (int i = 0; i < 3; i++) begin
            if (dec_hit[i]) begin
                sel_aluop  = dec_aluop[i];
                sel_alusel = dec_alusel[i];
                sel_imm    = dec_imm[i];
                sel_re1    = dec_re1[i];
                sel_re2    = dec_re2[i];
                sel_raddr1 = dec_raddr1[i];
                sel_raddr2 = dec_raddr2[i];
                sel_we     = dec_we[i];
                sel_waddr  = dec_waddr[i];
            end
        end
    end

    regfile u_regfile (
        .clk(clk), .rst(rst), .we(wb_en), .waddr(wb_addr), .wdata(wb_data),
        .re1(sel_re1), .raddr1(sel_raddr1), .re2(sel_re2), .raddr2(sel_raddr2),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    // control part of ID/EX, flush beats stall
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid        <= 1'b0;
            ex_reg_write_en <= 1'b0;
            ex_exception    <= 1'b0;
        end else if (flush) begin
            ex_valid        <= 1'b0;
            ex_reg_write_en <= 1'b0;
            ex_exception    <= 1'b0;
        end else if (!stall) begin
            ex_valid        <= if_valid;
            ex_reg_write_en <= if_valid & sel_we; // bubble writes nothing
            ex_exception    <= if_valid & no_hit;
        end
    end

    // payload part
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_pc              <= pc;
            ex_inst            <= inst;
            ex_aluop           <= sel_aluop;
            ex_alusel          <= sel_alusel;
            ex_imm             <= sel_imm;
            ex_reg1_data       <= rdata1;
            ex_reg2_data       <= rdata2;
            ex_reg_write_addr  <= sel_waddr;
            ex_exception_cause <= la_ctrl_pkg::EXC_INE;
        end
    end

endmodule

`default_nettype wire

// File: sim/id_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_sva (
    input wire        clk,
    input wire        rst,
    input wire        stall,
    input wire        flush,
    input wire        ex_valid,
    input wire [31:0] ex_pc,
    input wire [31:0] ex_inst,
    input wire  [7:0] ex_aluop,
    input wire  [2:0] ex_alusel,
    input wire [31:0] ex_imm,
    input wire [31:0] ex_reg1_data,
    input wire [31:0] ex_reg2_data,
    input wire        ex_reg_write_en,
    input wire  [4:0] ex_reg_write_addr,
    input wire        ex_exception,
    input wire  [6:0] ex_exception_cause,
    input wire  [4:0] rf_raddr1,
    input wire [31:0] rf_rdata1,
    input wire  [4:0] rf_raddr2,
    input wire [31:0] rf_rdata2
);

    int fail_count = 0; // failed assertions so far

    assert property (@(posedge clk) rst |=> !ex_valid && !ex_reg_write_en && !ex_exception)
        else begin
            fail_count++;
            $error("ID/EX control not cleared by reset");
        end

    assert property (@(posedge clk) disable iff (rst) flush |=> !ex_valid)
        else begin
            fail_count++;
            $error("ex_valid high the cycle after a flush");
        end

    property hold_on_stall;
        @(posedge clk) disable iff (rst)
        stall && !flush |=> $stable(ex_valid) && $stable(ex_pc) && $stable(ex_inst)
            && $stable(ex_aluop) && $stable(ex_alusel) && $stable(ex_imm)
            && $stable(ex_reg1_data) && $stable(ex_reg2_data) && $stable(ex_reg_write_en)
            && $stable(ex_reg_write_addr) && $stable(ex_exception)
            && $stable(ex_exception_cause);
    endproperty

    assert property (hold_on_stall)
        else begin
            fail_count++;
            $error("ID/EX outputs changed while stalled");
        end

    // r0 hard-wired to zero
    assert property (@(posedge clk) rf_raddr1 == 5'd0 |-> rf_rdata1 == 32'd0)
        else begin
            fail_count++;
            $error("read port 1 returned nonzero for r0");
        end

    assert property (@(posedge clk) rf_raddr2 == 5'd0 |-> rf_rdata2 == 32'd0)
        else begin
            fail_count++;
            $error("read port 2 returned nonzero for r0");
        end

endmodule

bind id_stage id_stage_sva u_sva (
    .clk(clk), .rst(rst), .stall(stall), .flush(flush),
    .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_inst(ex_inst), .ex_aluop(ex_aluop),
    .ex_alusel(ex_alusel), .ex_imm(ex_imm), .ex_reg1_data(ex_reg1_data),
    .ex_reg2_data(ex_reg2_data), .ex_reg_write_en(ex_reg_write_en),
    .ex_reg_write_addr(ex_reg_write_addr), .ex_exception(ex_exception),
    .ex_exception_cause(ex_exception_cause),
    .rf_raddr1(sel_raddr1), .rf_rdata1(rdata1), .rf_raddr2(sel_raddr2), .rf_rdata2(rdata2)
);

`default_nettype wire

// File: sim/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    localparam int NUM_INST   = 2000;
    localparam int MAX_CYCLES = NUM_INST * 3 / 2; // room for stalls, flushes and bubbles

    localparam logic [5:0] BR_OP [6] = '{la_isa_pkg::OP_BEQ, la_isa_pkg::OP_BNE,
        la_isa_pkg::OP_BLT, la_isa_pkg::OP_BGE, la_isa_pkg::OP_BLTU, la_isa_pkg::OP_BGEU};
    localparam logic [7:0] BR_ALU [6] = '{la_ctrl_pkg::ALU_BEQ, la_ctrl_pkg::ALU_BNE,
        la_ctrl_pkg::ALU_BLT, la_ctrl_pkg::ALU_BGE,
        la_ctrl_pkg::ALU_BLTU, la_ctrl_pkg::ALU_BGEU};
    // first three sign-extend, rest zero-extend
    localparam logic [9:0] RI_OP [6] = '{la_isa_pkg::OP_ADDI, la_isa_pkg::OP_SLTI,
        la_isa_pkg::OP_SLTUI, la_isa_pkg::OP_ANDI, la_isa_pkg::OP_ORI, la_isa_pkg::OP_XORI};
    localparam logic [7:0] RI_ALU [6] = '{la_ctrl_pkg::ALU_ADD, la_ctrl_pkg::ALU_SLT,
        la_ctrl_pkg::ALU_SLTU, la_ctrl_pkg::ALU_AND, la_ctrl_pkg::ALU_OR, la_ctrl_pkg::ALU_XOR};
    // first four are arith class
    localparam logic [16:0] RR_OP [8] = '{la_isa_pkg::OP_ADD, la_isa_pkg::OP_SUB,
        la_isa_pkg::OP_SLT, la_isa_pkg::OP_SLTU, la_isa_pkg::OP_AND, la_isa_pkg::OP_OR,
        la_isa_pkg::OP_XOR, la_isa_pkg::OP_NOR};
    localparam logic [7:0] RR_ALU [8] = '{la_ctrl_pkg::ALU_ADD, la_ctrl_pkg::ALU_SUB,
        la_ctrl_pkg::ALU_SLT, la_ctrl_pkg::ALU_SLTU, la_ctrl_pkg::ALU_AND, la_ctrl_pkg::ALU_OR,
        la_ctrl_pkg::ALU_XOR, la_ctrl_pkg::ALU_NOR};

    logic        clk;
    logic        rst;
    logic        if_valid;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        stall;
    logic        flush;
    logic        wb_en;
    logic  [4:0] wb_addr;
    logic [31:0] wb_data;
    logic        ex_valid;
    logic [31:0] ex_pc;
    logic [31:0] ex_inst;
    logic  [7:0] ex_aluop;
    logic  [2:0] ex_alusel;
    logic [31:0] ex_imm;
    logic [31:0] ex_reg1_data;
    logic [31:0] ex_reg2_data;
    logic        ex_reg_write_en;
    logic  [4:0] ex_reg_write_addr;
    logic        ex_exception;
    logic  [6:0] ex_exception_cause;

    logic [31:0] lfsr = 32'h379f12c7;
    logic [31:0] rnd;
    int          cycles = 0;
    int          accepted = 0;
    logic [31:0] shadow [32];

    // decode of the word now at the inputs
    logic        n_exc;
    logic  [7:0] n_aluop;
    logic  [2:0] n_sel;
    logic [31:0] n_imm;
    logic        n_re1;
    logic        n_re2;
    logic  [4:0] n_ra1;
    logic  [4:0] n_ra2;
    logic        n_we;
    logic  [4:0] n_wa;

    // predicted ID/EX contents
    logic        e_valid;
    logic        e_we;
    logic        e_exc;
    logic [31:0] e_pc;
    logic [31:0] e_inst;
    logic  [7:0] e_aluop;
    logic  [2:0] e_sel;
    logic [31:0] e_imm;
    logic [31:0] e_rd1;
    logic [31:0] e_rd2;
    logic  [4:0] e_wa;

    id_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32,22,2,1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_inst();
        logic [31:0] w;
        int          cls;
        int          k;
        w   = next_bits(32);
        cls = int'(next_bits(3));
        k   = int'(next_bits(3));
        case (cls)
            0, 1: w[31:22] = RI_OP[k % 6];
            2, 3: w[31:15] = RR_OP[k];
            4: w[31:26] = BR_OP[k % 6];
            5: w[31:26] = (k % 2 == 1) ? la_isa_pkg::OP_BL : la_isa_pkg::OP_B;
            6: w[31:26] = la_isa_pkg::OP_JIRL;
            default: w[31:26] = 6'h3f; // claimed by no format
        endcase
        return w;
    endfunction

    task automatic ref_decode(input logic [31:0] w);
        logic [31:0] offs_imm;
        offs_imm = {{14{w[25]}}, w[25:10], 2'b00};
        n_exc    = 1'b1;
        n_aluop  = la_ctrl_pkg::ALU_NOP;
        n_sel    = la_ctrl_pkg::SEL_NOP;
        n_imm    = 32'd0;
        {n_re1, n_re2, n_ra1, n_ra2, n_we, n_wa} = '0;
        for (int k = 0; k < 6; k++) begin
            if (w[31:22] == RI_OP[k]) begin
                n_exc   = 1'b0;
                n_aluop = RI_ALU[k];
                n_sel   = (k < 3) ? la_ctrl_pkg::SEL_ARITH : la_ctrl_pkg::SEL_LOGIC;
                n_imm   = (k < 3) ? {{20{w[21]}}, w[21:10]} : {20'd0, w[21:10]};
                n_re1   = 1'b1;
                n_ra1   = w[9:5];
                n_we    = 1'b1;
                n_wa    = w[4:0];
            end
            if (w[31:26] == BR_OP[k]) begin
                n_exc   = 1'b0;
                n_aluop = BR_ALU[k];
                n_sel   = la_ctrl_pkg::SEL_JUMP_BRANCH;
                n_imm   = offs_imm;
                {n_re1, n_re2} = 2'b11;
                n_ra1   = w[9:5];
                n_ra2   = w[4:0];
            end
        end
        for (int k = 0; k < 8; k++) begin
            if (w[31:15] == RR_OP[k]) begin
                n_exc   = 1'b0;
                n_aluop = RR_ALU[k];
                n_sel   = (k < 4) ? la_ctrl_pkg::SEL_ARITH : la_ctrl_pkg::SEL_LOGIC;
                {n_re1, n_re2, n_we} = 3'b111;
                n_ra1   = w[9:5];
                n_ra2   = w[14:10];
                n_wa    = w[4:0];
            end
        end
        if (w[31:26] == la_isa_pkg::OP_B || w[31:26] == la_isa_pkg::OP_BL) begin
            n_exc   = 1'b0;
            n_we    = (w[31:26] == la_isa_pkg::OP_BL);
            n_aluop = n_we ? la_ctrl_pkg::ALU_BL : la_ctrl_pkg::ALU_B;
            n_sel   = la_ctrl_pkg::SEL_JUMP_BRANCH;
            n_imm   = {{4{w[9]}}, w[9:0], w[25:10], 2'b00}; // offs26 = {rj, rd, offs16}
            n_wa    = n_we ? 5'd1 : 5'd0;
        end
        if (w[31:26] == la_isa_pkg::OP_JIRL) begin
            n_exc   = 1'b0;
            n_aluop = la_ctrl_pkg::ALU_JIRL;
            n_sel   = la_ctrl_pkg::SEL_JUMP_BRANCH;
            n_imm   = offs_imm;
            {n_re1, n_we} = 2'b11;
            n_ra1   = w[9:5];
            n_wa    = w[4:0];
        end
    endtask

    function automatic logic [31:0] read_port(input logic en, input logic [4:0] a);
        if (!en || a == 5'd0) begin
            return 32'd0;
        end
        if (wb_en && wb_addr == a) begin
            return wb_data; // writeback in the same cycle
        end
        return shadow[a];
    endfunction

    task automatic end_with_failure();
        $display("Verification failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    // reference ID/EX register and shadow register file
    always @(posedge clk) begin
        ref_decode(inst);
        if (rst) begin
            e_valid = 1'b0;
            e_we    = 1'b0;
            e_exc   = 1'b0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] = 32'd0;
            end
        end else begin
            if (flush) begin
                e_valid = 1'b0;
                e_we    = 1'b0;
                e_exc   = 1'b0;
            end else if (!stall) begin
                e_valid = if_valid;
                e_we    = if_valid & n_we;
                e_exc   = if_valid & n_exc;
            end
            if (!stall) begin
                e_pc    = pc;
                e_inst  = inst;
                e_aluop = n_aluop;
                e_sel   = n_sel;
                e_imm   = n_imm;
                e_wa    = n_wa;
                e_rd1   = read_port(n_re1, n_ra1);
                e_rd2   = read_port(n_re2, n_ra2);
            end
            if (wb_en && wb_addr != 5'd0) begin
                shadow[wb_addr] = wb_data;
            end
        end
    end

    always @(negedge clk) begin
        assert (DUT.u_sva.fail_count == 0) else begin
            $display("bound assertion on the DUT failed");
            end_with_failure();
        end
        if (!rst) begin
            check_field("ex_valid", 32'(e_valid), 32'(ex_valid));
            check_field("ex_reg_write_en", 32'(e_we), 32'(ex_reg_write_en));
            check_field("ex_exception", 32'(e_exc), 32'(ex_exception));
            if (e_valid) begin
                check_field("ex_pc", e_pc, ex_pc);
                check_field("ex_inst", e_inst, ex_inst);
                check_field("ex_aluop", 32'(e_aluop), 32'(ex_aluop));
                check_field("ex_alusel", 32'(e_sel), 32'(ex_alusel));
                check_field("ex_imm", e_imm, ex_imm);
                check_field("ex_reg1_data", e_rd1, ex_reg1_data);
                check_field("ex_reg2_data", e_rd2, ex_reg2_data);
                check_field("ex_reg_write_addr", 32'(e_wa), 32'(ex_reg_write_addr));
                if (e_exc) begin
                    check_field("ex_exception_cause", 32'(la_ctrl_pkg::EXC_INE),
                                32'(ex_exception_cause));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: only %0d of %0d instructions accepted in %0d cycles",
                     accepted, NUM_INST, MAX_CYCLES);
            end_with_failure();
        end
    end

    initial begin
        rst      = 1'b1;
        if_valid = 1'b0;
        pc       = 32'h1c000000;
        inst     = 32'd0;
        stall    = 1'b0;
        flush    = 1'b0;
        wb_en    = 1'b0;
        wb_addr  = 5'd0;
        wb_data  = 32'd0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // known value in every register, r0 write must be dropped
        for (int i = 0; i < 32; i++) begin
            wb_en   <= 1'b1;
            wb_addr <= i[4:0];
            wb_data <= 32'h9e3779b9 * 32'(i + 1);
            @(posedge clk);
        end
        while (accepted < NUM_INST) begin
            if (if_valid && !stall && !flush) begin
                accepted++;
            end
            if (!stall || flush) begin
                inst <= make_inst();
                pc   <= pc + 32'd4;
            end
            if_valid <= (next_bits(4) != 32'd0);
            stall    <= (next_bits(4) == 32'd0);
            flush    <= (next_bits(5) == 32'd0);
            wb_en    <= (next_bits(1) != 32'd0);
            rnd = next_bits(5);
            wb_addr  <= rnd[4:0];
            wb_data  <= next_bits(32);
            @(posedge clk);
        end
        if_valid <= 1'b0;
        repeat (2) @(negedge clk);
        if (DUT.u_sva.fail_count != 0) begin
            $display("bound assertion on the DUT failed");
            end_with_failure();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: files.f
hw/la_isa_pkg.sv
hw/la_ctrl_pkg.sv
hw/id_2ri16.sv
hw/id_2ri12.sv
hw/id_3r.sv
hw/regfile.sv
hw/id_stage.sv
sim/id_stage_sva.sv
sim/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_id_stage
FILELIST  := files.f
OBJ_DIR   := obj_dir

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
